/* hw/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address and register width
`define DC_XLEN 32

// block offset bits, 8-byte block
`define DC_BO 3

// index bits, 8 lines
`define DC_IDX_BITS 3

// miss table depth
`define DC_N_MSHR 4

// memory transaction tag width
`define DC_TAG_W 4

`endif

/* hw/mem_pkg.sv */
`include "dcache_cfg.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    typedef logic [`DC_TAG_W-1:0] mem_tag_t; // zero means no tag

    // one cache block seen as bytes, halves or words
    typedef union packed {
        logic [(1 << `DC_BO)-1:0][7:0]       bytes;
        logic [(1 << (`DC_BO-1))-1:0][15:0]  halves;
        logic [(1 << (`DC_BO-2))-1:0][31:0]  words;
    } block_t;

    typedef logic [`DC_XLEN-1:0] line_addr_t; // offset bits always zero

    typedef struct packed {
        logic       valid;
        logic       issued;   // accepted by memory, tag below is live
        logic       is_write; // eviction write-back, else line read
        mem_tag_t   tag;
        line_addr_t addr;
        block_t     wdata;
    } mshr_entry_t;

endpackage

/* hw/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;
    import mem_pkg::*;

    typedef enum logic {mem_read, mem_write} mem_op_t;

    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;

    typedef logic [`DC_XLEN-1:0] xlen_t;

    typedef enum logic [1:0] {ready, wait_mshr, wait_fill} dc_state_t;

    // returning line, table to cache
    typedef struct packed {
        logic       valid;
        line_addr_t addr;
        block_t     data;
    } fill_t;

    // load field, zero-extended
    function automatic xlen_t load_field(block_t blk, mem_size_t size,
                                         logic [`DC_BO-1:0] off);
        xlen_t val;
        val = '0;
        case (size)
            size_byte: val[7:0]  = blk.bytes[off];
            size_half: val[15:0] = blk.halves[off[`DC_BO-1:1]];
            size_word: val       = blk.words[off[`DC_BO-1:2]];
            default:   val       = '0;
        endcase
        return val;
    endfunction

    // store bytes into a block
    function automatic block_t store_merge(block_t blk, mem_size_t size,
                                           logic [`DC_BO-1:0] off, xlen_t wdata);
        block_t res;
        res = blk;
        case (size)
            size_byte: res.bytes[off]               = wdata[7:0];
            size_half: res.halves[off[`DC_BO-1:1]]  = wdata[15:0];
            size_word: res.words[off[`DC_BO-1:2]]   = wdata[31:0];
            default:   res                          = blk;
        endcase
        return res;
    endfunction

endpackage

/* hw/line_store.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module line_store
    import mem_pkg::*;
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       req_valid,
    input  mem_op_t    req_op,
    input  mem_size_t  req_size,
    input  xlen_t      req_addr,
    input  xlen_t      req_wdata,
    input  logic       accept_hit,  // ctrl took the request as a hit
    input  fill_t      fill,
    input  mem_op_t    merge_op,    // held miss request
    input  mem_size_t  merge_size,
    input  xlen_t      merge_addr,
    input  xlen_t      merge_wdata,
    output logic       hit,
    output block_t     hit_data,
    output logic       evict_valid,
    output line_addr_t evict_addr,
    output block_t     evict_data
);
    localparam int N_LINES = 1 << `DC_IDX_BITS;
    localparam int LTAG_W  = `DC_XLEN - `DC_IDX_BITS - `DC_BO;

    logic [N_LINES-1:0] valid_q;
    logic [N_LINES-1:0] dirty_q;
    logic [LTAG_W-1:0]  tag_q  [N_LINES];
    block_t             data_q [N_LINES];

    logic [`DC_IDX_BITS-1:0] req_idx;
    logic [LTAG_W-1:0]       req_tag;
    logic [`DC_IDX_BITS-1:0] fill_idx;
    logic [LTAG_W-1:0]       fill_tag;
    logic                    store_hit;
    logic                    fill_store; // the miss being filled is a store
    block_t                  hit_merged;
    block_t                  fill_merged;

    assign req_idx  = req_addr[`DC_BO +: `DC_IDX_BITS];
    assign req_tag  = req_addr[`DC_XLEN-1 -: LTAG_W];
    assign fill_idx = fill.addr[`DC_BO +: `DC_IDX_BITS];
    assign fill_tag = fill.addr[`DC_XLEN-1 -: LTAG_W];

    // direct-mapped lookup, one way to compare
    assign hit      = req_valid && valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign hit_data = data_q[req_idx];

    assign store_hit  = accept_hit && (req_op == mem_write);
    assign fill_store = (merge_op == mem_write);

    assign hit_merged  = store_merge(hit_data, req_size, req_addr[`DC_BO-1:0], req_wdata);
    assign fill_merged = fill_store ?
        store_merge(fill.data, merge_size, merge_addr[`DC_BO-1:0], merge_wdata) : fill.data;

    // old line leaves only if it holds unwritten data
    assign evict_valid = fill.valid && valid_q[fill_idx] && dirty_q[fill_idx];
    assign evict_addr  = {tag_q[fill_idx], fill_idx, {`DC_BO{1'b0}}};
    assign evict_data  = data_q[fill_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill.valid) begin
            valid_q[fill_idx] <= 1'b1;
            dirty_q[fill_idx] <= fill_store; // clean unless the store lands now
        end else if (store_hit) begin
            dirty_q[req_idx] <= 1'b1;
        end
    end

    // fill and store hit never share a cycle, ctrl is in different states
    always_ff @(posedge clock) begin
        if (fill.valid) begin
            tag_q[fill_idx]  <= fill_tag;
            data_q[fill_idx] <= fill_merged;
        end else if (store_hit) begin
            data_q[req_idx] <= hit_merged;
        end
    end

endmodule

/* hw/mshr_table.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module mshr_table
    import mem_pkg::*;
    import dcache_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        alloc_valid,  // read entry for a miss
    input  line_addr_t                  alloc_addr,
    input  logic                        evict_valid,  // write entry for a dirty victim
    input  line_addr_t                  evict_addr,
    input  block_t                      evict_data,
    input  mem_tag_t                    mem_response, // nonzero accepts the offer
    input  mem_tag_t                    mem_tag,
    input  block_t                      mem_rdata,
    output bus_command_t                mem_command,
    output line_addr_t                  mem_addr,
    output block_t                      mem_wdata,
    output fill_t                       fill,
    output logic [$clog2(`DC_N_MSHR):0] n_free
);
    localparam int N  = `DC_N_MSHR;
    localparam int IW = $clog2(N);

    mshr_entry_t tbl      [N];
    mshr_entry_t tbl_next [N];

    logic          wr_found;
    logic [IW-1:0] wr_idx;
    logic          rd_found;
    logic [IW-1:0] rd_idx;
    logic          iss_found;
    logic [IW-1:0] iss_idx;
    logic          free_found;
    logic [IW-1:0] free_idx;
    logic          match_found;
    logic [IW-1:0] match_idx;
    logic [IW:0]   free_cnt;

    // one pass finds free slot, issue candidates and the tag match
    always_comb begin
        wr_found    = 1'b0;
        wr_idx      = '0;
        rd_found    = 1'b0;
        rd_idx      = '0;
        free_found  = 1'b0;
        free_idx    = '0;
        match_found = 1'b0;
        match_idx   = '0;
        free_cnt    = '0;
        for (int i = 0; i < N; i++) begin
            if (!tbl[i].valid) begin
                free_cnt = free_cnt + 1'b1;
                if (!free_found) begin
                    free_found = 1'b1;
                    free_idx   = IW'(i); // lowest free slot
                end
            end else if (!tbl[i].issued) begin
                if (tbl[i].is_write && !wr_found) begin
                    wr_found = 1'b1;
                    wr_idx   = IW'(i);
                end else if (!tbl[i].is_write && !rd_found) begin
                    rd_found = 1'b1;
                    rd_idx   = IW'(i);
                end
            end else if ((mem_tag != '0) && (tbl[i].tag == mem_tag) && !match_found) begin
                match_found = 1'b1; // issued entries are always reads
                match_idx   = IW'(i);
            end
        end
    end

    // writes go first so a victim reaches memory before any later read of it
    assign iss_found = wr_found || rd_found;
    assign iss_idx   = wr_found ? wr_idx : rd_idx;

    assign mem_command = !iss_found          ? bus_none  :
                         tbl[iss_idx].is_write ? bus_store : bus_load;
    assign mem_addr    = tbl[iss_idx].addr;
    assign mem_wdata   = tbl[iss_idx].wdata;

    assign fill.valid = match_found;
    assign fill.addr  = tbl[match_idx].addr;
    assign fill.data  = mem_rdata;

    assign n_free = free_cnt;

    always_comb begin
        tbl_next = tbl;
        if (match_found) begin
            tbl_next[match_idx].valid = 1'b0; // read done
        end
        if (iss_found && (mem_response != '0)) begin
            if (tbl[iss_idx].is_write) begin
                tbl_next[iss_idx].valid = 1'b0; // store applied on accept
            end else begin
                tbl_next[iss_idx].issued = 1'b1;
                tbl_next[iss_idx].tag    = mem_response;
            end
        end
        // alloc and evict come from different ctrl states, never together
        if ((alloc_valid || evict_valid) && free_found) begin
            tbl_next[free_idx].valid    = 1'b1;
            tbl_next[free_idx].issued   = 1'b0;
            tbl_next[free_idx].is_write = evict_valid;
            tbl_next[free_idx].tag      = '0;
            tbl_next[free_idx].addr     = evict_valid ? evict_addr : alloc_addr;
            tbl_next[free_idx].wdata    = evict_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                tbl[i].valid  <= 1'b0;
                tbl[i].issued <= 1'b0;
            end
        end else begin
            tbl <= tbl_next;
        end
    end

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_ctrl
    import mem_pkg::*;
    import dcache_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        req_valid,
    input  mem_op_t                     req_op,
    input  mem_size_t                   req_size,
    input  xlen_t                       req_addr,
    input  xlen_t                       req_wdata,
    input  logic                        hit,
    input  block_t                      hit_data,
    input  fill_t                       fill,
    input  logic [$clog2(`DC_N_MSHR):0] n_free,
    output logic                        stall,
    output logic                        accept_hit,
    output logic                        alloc_valid,
    output line_addr_t                  alloc_addr,
    output mem_op_t                     merge_op,
    output mem_size_t                   merge_size,
    output xlen_t                       merge_addr,
    output xlen_t                       merge_wdata,
    output logic                        resp_valid,
    output xlen_t                       resp_data
);
    dc_state_t state;
    dc_state_t state_next;
    mem_op_t   hold_op;     // missed request, kept until its fill
    mem_size_t hold_size;
    xlen_t     hold_addr;
    xlen_t     hold_wdata;
    logic      miss;
    logic      room;        // one entry for the read, one for a victim
    logic      fill_done;
    xlen_t     miss_addr;
    xlen_t     resp_next;

    assign stall      = (state != ready);
    assign accept_hit = (state == ready) && req_valid && hit;
    assign miss       = (state == ready) && req_valid && !hit;
    assign room       = (n_free >= 2);
    assign fill_done  = (state == wait_fill) && fill.valid;

    assign alloc_valid = (miss || (state == wait_mshr)) && room;
    assign miss_addr   = (state == ready) ? req_addr : hold_addr;
    assign alloc_addr  = {miss_addr[`DC_XLEN-1:`DC_BO], {`DC_BO{1'b0}}};

    assign merge_op    = hold_op;
    assign merge_size  = hold_size;
    assign merge_addr  = hold_addr;
    assign merge_wdata = hold_wdata;

    always_comb begin
        state_next = state;
        case (state)
            ready:     if (miss) state_next = room ? wait_fill : wait_mshr;
            wait_mshr: if (room) state_next = wait_fill;
            wait_fill: if (fill.valid) state_next = ready;
            default:   state_next = ready;
        endcase
    end

    // stores answer zero
    always_comb begin
        resp_next = '0;
        if (accept_hit && (req_op == mem_read)) begin
            resp_next = load_field(hit_data, req_size, req_addr[`DC_BO-1:0]);
        end else if (fill_done && (hold_op == mem_read)) begin
            resp_next = load_field(fill.data, hold_size, hold_addr[`DC_BO-1:0]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ready;
            resp_valid <= 1'b0;
        end else begin
            state      <= state_next;
            resp_valid <= accept_hit || fill_done; // one cycle after hit or fill
        end
    end

    always_ff @(posedge clock) begin
        resp_data <= resp_next;
        if (miss) begin
            hold_op    <= req_op;
            hold_size  <= req_size;
            hold_addr  <= req_addr;
            hold_wdata <= req_wdata;
        end
    end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_top
    import mem_pkg::*;
    import dcache_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         req_valid,
    input  mem_op_t      req_op,
    input  mem_size_t    req_size,
    input  xlen_t        req_addr,
    input  xlen_t        req_wdata,
    output logic         stall,
    output logic         resp_valid,
    output xlen_t        resp_data,
    output bus_command_t mem_command,
    output line_addr_t   mem_addr,
    output block_t       mem_wdata,
    input  mem_tag_t     mem_response,
    input  mem_tag_t     mem_tag,
    input  block_t       mem_rdata
);
    logic                        hit;
    block_t                      hit_data;
    logic                        accept_hit;
    fill_t                       fill;       // table to lines and ctrl
    logic                        evict_valid;
    line_addr_t                  evict_addr;
    block_t                      evict_data;
    logic                        alloc_valid;
    line_addr_t                  alloc_addr;
    logic [$clog2(`DC_N_MSHR):0] n_free;
    mem_op_t                     merge_op;
    mem_size_t                   merge_size;
    xlen_t                       merge_addr;
    xlen_t                       merge_wdata;

    line_store line_store_i (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .accept_hit, .fill, .merge_op, .merge_size, .merge_addr, .merge_wdata,
        .hit, .hit_data, .evict_valid, .evict_addr, .evict_data
    );

    mshr_table mshr_table_i (
        .clock, .reset, .alloc_valid, .alloc_addr, .evict_valid, .evict_addr,
        .evict_data, .mem_response, .mem_tag, .mem_rdata, .mem_command,
        .mem_addr, .mem_wdata, .fill, .n_free
    );

    dcache_ctrl dcache_ctrl_i (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .hit, .hit_data, .fill, .n_free, .stall, .accept_hit, .alloc_valid,
        .alloc_addr, .merge_op, .merge_size, .merge_addr, .merge_wdata,
        .resp_valid, .resp_data
    );

endmodule

/* test/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock; // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
    end
endmodule

/* test/dcache_asserts.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_asserts
    import mem_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input bus_command_t mem_command,
    input line_addr_t   mem_addr,
    input mem_tag_t     mem_response,
    input logic         fill_valid,
    input logic         resp_valid
);
    logic [1:0] rd_outstanding; // accepted line reads not yet filled
    logic       load_accept;

    assign load_accept = (mem_command == bus_load) && (mem_response != '0);

    always_ff @(posedge clock) begin
        if (reset) rd_outstanding <= '0;
        else rd_outstanding <= rd_outstanding + 2'(load_accept) - 2'(fill_valid);
    end

    a_aligned: assert property (@(posedge clock) disable iff (reset)
        (mem_command != bus_none) |-> (mem_addr[`DC_BO-1:0] == '0))
        else $error("bus address not block aligned");

    a_one_read: assert property (@(posedge clock) disable iff (reset)
        load_accept |-> (rd_outstanding == 0))
        else $error("more than one line read outstanding");

    a_resp_gap: assert property (@(posedge clock) disable iff (reset)
        resp_valid |=> !resp_valid)
        else $error("resp_valid high two cycles in a row");
endmodule

bind dcache_top dcache_asserts asserts_i (
    .clock, .reset, .mem_command, .mem_addr, .mem_response,
    .fill_valid(fill.valid), .resp_valid
);

/* test/dcache_tb.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_tb
    import mem_pkg::*;
    import dcache_pkg::*;
;
    logic clock, reset;
    logic req_valid;
    mem_op_t req_op;
    mem_size_t req_size;
    xlen_t req_addr, req_wdata, resp_data;
    logic stall, resp_valid;
    bus_command_t mem_command;
    line_addr_t mem_addr;
    block_t mem_wdata, mem_rdata;
    mem_tag_t mem_response, mem_tag;

    logic [7:0] mem_bytes [xlen_t];  // memory model contents
    logic [7:0] gold_bytes [xlen_t]; // golden view updated at each store response
    mem_tag_t rd_tag_q [$];
    block_t rd_data_q [$];
    int rd_due_q [$];
    mem_tag_t next_tag;
    int cycle, store_count, error_count;
    string cur_test;
    mem_op_t p_op; // request in flight
    mem_size_t p_size;
    xlen_t p_addr, p_wdata;

    clock_gen clock_gen_i (.clock, .reset);

    dcache_top dut_i (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .stall, .resp_valid, .resp_data, .mem_command, .mem_addr, .mem_wdata,
        .mem_response, .mem_tag, .mem_rdata
    );

    function automatic logic [7:0] init_byte(xlen_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ {a[2:0], a[7:3]} ^ 8'h3c;
    endfunction

    function automatic logic [7:0] mem_byte(xlen_t a);
        return mem_bytes.exists(a) ? mem_bytes[a] : init_byte(a);
    endfunction

    function automatic logic [7:0] gold_byte(xlen_t a);
        return gold_bytes.exists(a) ? gold_bytes[a] : init_byte(a);
    endfunction

    function automatic int size_bytes(mem_size_t s);
        return (s == size_byte) ? 1 : (s == size_half) ? 2 : 4;
    endfunction

    // little-endian expected load value zero-extended to xlen
    function automatic xlen_t golden_load(xlen_t addr, mem_size_t size);
        xlen_t v;
        v = '0;
        for (int i = 0; i < size_bytes(size); i++) v[8*i +: 8] = gold_byte(addr + i);
        return v;
    endfunction

    function automatic block_t golden_block(line_addr_t a);
        block_t b;
        for (int i = 0; i < 8; i++) b.bytes[i] = gold_byte(a + i);
        return b;
    endfunction

    task automatic fail_now(string msg);
        $display("%s: %s", cur_test, msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(string what, xlen_t expected, xlen_t actual);
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED %s %s expected %h actual %h",
                     cur_test, what, expected, actual);
            fail_now("data mismatch");
        end
    endtask

    task automatic check_block(string what, block_t expected, block_t actual);
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED %s %s expected %h actual %h",
                     cur_test, what, expected, actual);
            fail_now("block mismatch");
        end
    endtask

    // tagged memory with random accepts and reads back 1 to 8 cycles later
    always @(posedge clock) begin
        if (reset) begin
            next_tag = 1;
            cycle = 0;
            mem_response <= '0;
            mem_tag <= '0;
        end else begin
            if ((mem_command != bus_none) && (mem_response != '0)) begin
                if (mem_command == bus_store) begin
                    check_block("evicted line", golden_block(mem_addr), mem_wdata);
                    for (int i = 0; i < 8; i++) mem_bytes[mem_addr + i] = mem_wdata.bytes[i];
                    store_count++;
                end else begin
                    block_t b;
                    for (int i = 0; i < 8; i++) b.bytes[i] = mem_byte(mem_addr + i);
                    rd_tag_q.push_back(mem_response);
                    rd_data_q.push_back(b);
                    rd_due_q.push_back(cycle + 1 + int'($urandom % 8));
                end
                next_tag = (next_tag == 15) ? 4'd1 : next_tag + 4'd1;
            end
            mem_response <= (($urandom % 10) < 7) ? next_tag : '0;
            mem_tag <= '0;
            if ((rd_due_q.size() > 0) && (rd_due_q[0] <= cycle)) begin
                mem_tag <= rd_tag_q.pop_front();
                mem_rdata <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end
            cycle++;
        end
    end

    // capture each accepted request and check its response
    always @(posedge clock) begin
        if (!reset) begin
            if (req_valid && !stall) begin
                p_op = req_op;
                p_size = req_size;
                p_addr = req_addr;
                p_wdata = req_wdata;
            end
            if (resp_valid) begin
                if (p_op == mem_read) begin
                    check_data("load", golden_load(p_addr, p_size), resp_data);
                end else begin
                    check_data("store resp", '0, resp_data);
                    for (int i = 0; i < size_bytes(p_size); i++)
                        gold_bytes[p_addr + i] = p_wdata[8*i +: 8];
                end
            end
        end
    end

    task automatic access(mem_op_t op, mem_size_t size, xlen_t addr, xlen_t wdata);
        int n;
        @(posedge clock);
        req_valid <= 1'b1;
        req_op <= op;
        req_size <= size;
        req_addr <= addr;
        req_wdata <= wdata;
        n = 0;
        do begin
            @(posedge clock);
            n++;
            if (n > 300) fail_now("request was never accepted");
        end while (stall);
        req_valid <= 1'b0;
        n = 0;
        while (!resp_valid) begin
            @(posedge clock);
            n++;
            if (n > 300) fail_now("no response to an accepted request");
        end
    endtask

    task automatic wait_stores(int target);
        int n;
        n = 0;
        while (store_count < target) begin
            @(posedge clock);
            n++;
            if (n > 300) fail_now("dirty line write-back never reached memory");
        end
    endtask

    task automatic idle(int cycles);
        for (int i = 0; i < cycles; i++) @(posedge clock);
    endtask

    initial begin
        int n;
        int stores_before;
        xlen_t a;
        mem_size_t s;
        void'($urandom(64));
        req_valid = 1'b0;
        req_op = mem_read;
        req_size = size_byte;
        req_addr = '0;
        req_wdata = '0;
        mem_response = '0;
        mem_tag = '0;
        mem_rdata = '0;
        store_count = 0;
        error_count = 0;
        cur_test = "reset";
        n = 0;
        do begin
            @(posedge clock);
            n++;
            if (n > 20) fail_now("reset never released");
        end while (reset);
        check_data("stall", '0, xlen_t'(stall));
        check_data("resp_valid", '0, xlen_t'(resp_valid));
        check_data("mem_command", xlen_t'(bus_none), xlen_t'(mem_command));

        cur_test = "miss_then_hit";
        access(mem_read, size_word, 32'h0000_0128, '0);
        access(mem_read, size_half, 32'h0000_012e, '0);

        cur_test = "sizes";
        access(mem_write, size_byte, 32'h0000_0131, 32'h0000_00a5); // miss
        access(mem_write, size_half, 32'h0000_0136, 32'h0000_beef); // hit
        access(mem_write, size_word, 32'h0000_0230, 32'h1234_5678); // miss that evicts
        access(mem_read, size_word, 32'h0000_0130, '0);
        access(mem_read, size_word, 32'h0000_0234, '0);
        access(mem_read, size_byte, 32'h0000_0233, '0);

        cur_test = "eviction";
        access(mem_write, size_word, 32'h0000_0048, 32'hcafe_f00d);
        stores_before = store_count;
        access(mem_read, size_word, 32'h0000_0448, '0); // dirty victim
        wait_stores(stores_before + 1);
        stores_before = store_count;
        access(mem_read, size_byte, 32'h0000_0848, '0); // clean victim
        idle(30);
        check_data("clean evict stores", xlen_t'(stores_before), xlen_t'(store_count));

        cur_test = "random_mix";
        for (int k = 0; k < 400; k++) begin
            s = mem_size_t'($urandom % 3);
            a = {(($urandom % 3) << 6) | (($urandom % 2) << 3)};
            a = a | (xlen_t'($urandom % 8) & ~xlen_t'(size_bytes(s) - 1));
            if ($urandom % 2) access(mem_write, s, a, $urandom);
            else access(mem_read, s, a, '0);
        end

        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

/* dcache.f */
+incdir+hw
hw/mem_pkg.sv
hw/dcache_pkg.sv
hw/line_store.sv
hw/mshr_table.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
test/clock_gen.sv
test/dcache_asserts.sv
test/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module dcache_tb -f dcache.f -o sim_dcache
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
